//--- Bender.yml
package:
  name: ram_var

export_include_dirs:
  - include

sources:
  - hdl/ram_var_pkg.sv
  - hdl/ram_wr_if.sv
  - hdl/ram_write_port.sv
  - hdl/ram_read_port.sv
  - hdl/ram_row_array.sv
  - hdl/ram_var_top.sv

  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_ram_var.sv

//--- hdl/ram_read_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Variable width read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ram_var_settings.svh"

module ram_read_port import ram_var_pkg::*; #(
   parameter integer LOG2WIDTH_RD = 5,                              // Read width is 1 << this
   parameter integer REGISTERS    = 0                               // 1 adds the output register
) (
   input  logic                                       rclk_i,       // Read clock
   input  logic                                       rst_n_i,      // Async reset, active low
   input  logic [`RAM_BIT_ADDR_BITS-LOG2WIDTH_RD-1:0] raddr_i,      // Word address
   input  logic                                       ren_i,        // Read enable
   input  logic                                       regen_i,      // Output register enable
   output row_addr_t                                  rd_row_o,     // Row to the array
   output logic                                       rd_en_o,      // Array read enable
   input  row_t                                       rd_data_i,    // Row latched by the array
   output logic [(1 << LOG2WIDTH_RD)-1:0]             data_out_o    // Read slice
);

   localparam integer WIDTH_RD      = 1 << LOG2WIDTH_RD;
   localparam integer BIT_ADDR_BITS = `RAM_BIT_ADDR_BITS;
   localparam integer OFF_BITS      = $clog2(`RAM_ROW_BITS);

   logic [BIT_ADDR_BITS-1:0] bit_addr;                              // Address of the first bit
   logic [OFF_BITS-1:0]      rd_off_q;                              // Offset of the pending read
   row_t                     slice_row;                             // Row moved down to bit 0
   logic [WIDTH_RD-1:0]      slice;                                 // Selected word

   assign bit_addr = BIT_ADDR_BITS'(raddr_i) << LOG2WIDTH_RD;
   assign rd_row_o = bit_addr[BIT_ADDR_BITS-1:OFF_BITS];            // Divide by row width
   assign rd_en_o  = ren_i;

   // Offset follows the row into the array latch, same edge
   always_ff @(posedge rclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_off_q <= '0;
      end else if (ren_i) begin
         rd_off_q <= bit_addr[OFF_BITS-1:0];                        // Held while ren_i is low
      end
   end

   assign slice_row = rd_data_i >> rd_off_q;                        // Lower address in lower bits
   assign slice     = slice_row[WIDTH_RD-1:0];

   generate
      if (REGISTERS != 0) begin : g_out_reg
         logic [WIDTH_RD-1:0] out_q;                                // Output register

         always_ff @(posedge rclk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
               out_q <= '0;
            end else if (regen_i) begin
               out_q <= slice;                                      // Holds while regen_i is low
            end
         end

         assign data_out_o = out_q;                                 // Two cycles with regen high
      end else begin : g_out_comb
         assign data_out_o = slice;                                 // One cycle after ren_i
      end
   endgenerate

endmodule

//--- hdl/ram_row_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 512 x 32 row storage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ram_var_settings.svh"

module ram_row_array import ram_var_pkg::*; (
   input  logic      wclk_i,                                        // Write clock
   input  logic      rclk_i,                                        // Read clock
   input  logic      rst_n_i,                                       // Clears the read latch only
   ram_wr_if.wr_dst  wr,                                            // Masked row write
   input  row_addr_t rd_row_i,                                      // Row to read
   input  logic      rd_en_i,                                       // Read enable
   output row_t      rd_data_o                                      // Latched row
);

   localparam integer ROWS = 1 << `RAM_ROW_ADDR_BITS;

   row_t mem [ROWS];                                                // Storage, not reset
   row_t rd_data_q;

   // Bits outside the mask keep their old value
   always_ff @(posedge wclk_i) begin
      if (wr.wr_stb) begin
         mem[wr.row_addr] <= (mem[wr.row_addr] & ~wr.bit_mask) | (wr.row_data & wr.bit_mask);
      end
   end

   // Same-row read and write on one edge is undefined
   always_ff @(posedge rclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_data_q <= '0;
      end else if (rd_en_i) begin
         rd_data_q <= mem[rd_row_i];                                // Held while rd_en_i is low
      end
   end

   assign rd_data_o = rd_data_q;

endmodule

//--- hdl/ram_var_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Half RAM shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ram_var_settings.svh"

package ram_var_pkg;

   // One row of data, also a per-bit write mask
   typedef logic [`RAM_ROW_BITS-1:0] row_t;

   // Row index into the array
   typedef logic [`RAM_ROW_ADDR_BITS-1:0] row_addr_t;

   // Byte write enables
   typedef logic [`RAM_LANES-1:0] web_t;

endpackage

//--- hdl/ram_var_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Variable width half RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ram_var_settings.svh"

module ram_var_top import ram_var_pkg::*; #(
   parameter integer LOG2WIDTH_WR = 5,                              // Write width is 1 << this
   parameter integer LOG2WIDTH_RD = 5,                              // Read width is 1 << this
   parameter integer REGISTERS    = 0                               // 1 adds the output register
) (
   input  logic                                       rst_n_i,      // Read side reset
   // Write side
   input  logic                                       wclk_i,       // Write clock
   input  logic [`RAM_BIT_ADDR_BITS-LOG2WIDTH_WR-1:0] waddr_i,      // Write address
   input  logic                                       we_i,         // Write enable
   input  web_t                                       web_i,        // Byte write enables
   input  logic [(1 << LOG2WIDTH_WR)-1:0]             data_in_i,    // Write data
   // Read side
   input  logic                                       rclk_i,       // Read clock
   input  logic [`RAM_BIT_ADDR_BITS-LOG2WIDTH_RD-1:0] raddr_i,      // Read address
   input  logic                                       ren_i,        // Read enable
   input  logic                                       regen_i,      // Output register enable
   output logic [(1 << LOG2WIDTH_RD)-1:0]             data_out_o    // Read data
);

   row_addr_t rd_row;                                               // Read row to the array
   logic      rd_en;
   row_t      rd_data;                                              // Row back from the array

   ram_wr_if wr_bus ();                                             // Write port to storage

   ram_write_port #(
      .LOG2WIDTH_WR (LOG2WIDTH_WR)
   ) u_write_port (
      .waddr_i      (waddr_i),
      .we_i         (we_i),
      .web_i        (web_i),
      .data_in_i    (data_in_i),
      .wr           (wr_bus.wr_src)
   );

   ram_row_array u_row_array (
      .wclk_i       (wclk_i),
      .rclk_i       (rclk_i),
      .rst_n_i      (rst_n_i),
      .wr           (wr_bus.wr_dst),
      .rd_row_i     (rd_row),
      .rd_en_i      (rd_en),
      .rd_data_o    (rd_data)
   );

   ram_read_port #(
      .LOG2WIDTH_RD (LOG2WIDTH_RD),
      .REGISTERS    (REGISTERS)
   ) u_read_port (
      .rclk_i       (rclk_i),
      .rst_n_i      (rst_n_i),
      .raddr_i      (raddr_i),
      .ren_i        (ren_i),
      .regen_i      (regen_i),
      .rd_row_o     (rd_row),
      .rd_en_o      (rd_en),
      .rd_data_i    (rd_data),
      .data_out_o   (data_out_o)
   );

endmodule

//--- hdl/ram_wr_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Masked row write bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface ram_wr_if;

   ram_var_pkg::row_addr_t row_addr; // Target row
   ram_var_pkg::row_t      bit_mask; // Set bits take new data
   ram_var_pkg::row_t      row_data; // Write word placed at its offset
   logic                   wr_stb;   // Write this wclk edge

   // Write port side
   modport wr_src (
      output row_addr,
      output bit_mask,
      output row_data,
      output wr_stb
   );

   // Storage side, sampled on wclk
   modport wr_dst (
      input row_addr,
      input bit_mask,
      input row_data,
      input wr_stb
   );

endinterface

//--- hdl/ram_write_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Variable width write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ram_var_settings.svh"

module ram_write_port import ram_var_pkg::*; #(
   parameter integer LOG2WIDTH_WR = 5                                // Write width is 1 << this
) (
   input  logic [`RAM_BIT_ADDR_BITS-LOG2WIDTH_WR-1:0] waddr_i,       // Word address
   input  logic                                       we_i,          // Write enable
   input  web_t                                       web_i,         // Byte write enables
   input  logic [(1 << LOG2WIDTH_WR)-1:0]             data_in_i,     // Write word
   ram_wr_if.wr_src                                   wr             // Row write to the array
);

   localparam integer WIDTH_WR      = 1 << LOG2WIDTH_WR;
   localparam integer BIT_ADDR_BITS = `RAM_BIT_ADDR_BITS;
   localparam integer OFF_BITS      = $clog2(`RAM_ROW_BITS);        // Bit offset inside a row
   localparam integer REPS          = `RAM_ROW_BITS / WIDTH_WR;     // Copies of the word per row

   logic [BIT_ADDR_BITS-1:0] bit_addr;                              // Address of the first bit
   logic [OFF_BITS-1:0]      bit_off;                               // Word position in the row
   web_t                     lane_en;                               // Byte lanes allowed to change
   row_t                     lane_mask;                             // Lane enables, one per bit
   row_t                     width_mask;                            // Bits covered by the word

   assign bit_addr = BIT_ADDR_BITS'(waddr_i) << LOG2WIDTH_WR;       // Word address times width
   assign bit_off  = bit_addr[OFF_BITS-1:0];                        // Modulo row width

   // Full and half words take web from bit 0 up, moved to their lanes
   // Bytes and narrower are all gated by web bit 0
   always_comb begin
      if (LOG2WIDTH_WR >= 4) begin
         lane_en = web_t'(web_i << bit_off[OFF_BITS-1:OFF_BITS-2]); // Shift by byte position
      end else begin
         lane_en = {`RAM_LANES{web_i[0]}};                          // One enable for the word
      end
   end

   always_comb begin
      for (int k = 0; k < `RAM_LANES; k++) begin
         lane_mask[k*`RAM_BYTE_BITS +: `RAM_BYTE_BITS] = {`RAM_BYTE_BITS{lane_en[k]}};
      end
   end

   assign width_mask = row_t'({WIDTH_WR{1'b1}}) << bit_off;         // Word footprint, low bits first

   assign wr.row_addr = bit_addr[BIT_ADDR_BITS-1:OFF_BITS];         // Divide by row width
   assign wr.bit_mask = width_mask & lane_mask;
   assign wr.row_data = {REPS{data_in_i}};                          // Aligned at every offset
   assign wr.wr_stb   = we_i;

endmodule

//--- include/ram_var_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Half RAM geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef RAM_VAR_SETTINGS_SVH
`define RAM_VAR_SETTINGS_SVH

// Bit address into the 16 Kbit array
`define RAM_BIT_ADDR_BITS 14

`define RAM_ROW_BITS      32 // One storage row
`define RAM_ROW_ADDR_BITS 9  // 512 rows
`define RAM_BYTE_BITS     8  // One byte lane
`define RAM_LANES         4  // Byte lanes per row, also web width

`endif

//--- ram_var.f
+incdir+include
hdl/ram_var_pkg.sv
hdl/ram_wr_if.sv
hdl/ram_write_port.sv
hdl/ram_read_port.sv
hdl/ram_row_array.sv
hdl/ram_var_top.sv
sim/tb_clock_gen.sv
sim/tb_ram_var.sv

//--- sim/ram_var_stimulus.txt
# Columns: op addr data web expect, all hex after the op letter
# W writes data under web, R reads with regen high, H reads with regen low two cycles
W 010 a1b2c3d4 f 00
R 040 00000000 0 d4
R 041 00000000 0 c3
R 042 00000000 0 b2
R 043 00000000 0 a1
W 010 55667788 5 00
R 040 00000000 0 88
R 041 00000000 0 c3
R 042 00000000 0 66
R 043 00000000 0 a1
H 041 00000000 0 c3
W 1ff 0badf00d f 00
R 7fc 00000000 0 0d
R 7ff 00000000 0 0b
H 7fd 00000000 0 f0
R 7fe 00000000 0 ad
W 000 12345678 f 00
W 000 ffffffff 8 00
R 003 00000000 0 ff
R 000 00000000 0 78
R 001 00000000 0 56
W 001 cafebabe 3 00
R 004 00000000 0 be
R 005 00000000 0 ba
W 010 00000000 2 00
H 041 00000000 0 00
R 043 00000000 0 a1
R 042 00000000 0 66
H 7fc 00000000 0 0d
R 040 00000000 0 88

//--- sim/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter integer PERIOD_NS    = 40,                            // Clock period
   parameter integer RESET_CYCLES = 3                              // Reset length in cycles
) (
   output logic clk_o,                                             // Free running clock
   output logic rst_n_o                                            // Active low reset
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Released on a rising edge
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

//--- sim/tb_ram_var.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Half RAM testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ram_var_settings.svh"

module tb_ram_var;

   localparam integer LOG2_WR      = 5;                            // 32 bit writes
   localparam integer LOG2_RD      = 3;                            // 8 bit reads
   localparam integer WADDR_BITS   = `RAM_BIT_ADDR_BITS - LOG2_WR;
   localparam integer RADDR_BITS   = `RAM_BIT_ADDR_BITS - LOG2_RD;
   localparam integer READ_LATENCY = 2;                            // From ren edge to output
   localparam integer EDGE_LIMIT   = 16;                           // Longest plain edge wait
   localparam integer RESET_LIMIT  = 20;                           // Cycles allowed for reset
   localparam integer RUN_LIMIT_NS = 100000;
   localparam integer SEED         = 39255;

   logic                                 clk;
   logic                                 rst_n;
   logic [WADDR_BITS-1:0]                waddr;
   logic                                 we;
   logic [`RAM_LANES-1:0]                web;
   logic [(1 << LOG2_WR)-1:0]            data_in;
   logic [RADDR_BITS-1:0]                raddr;
   logic                                 ren;
   logic                                 regen;
   logic [(1 << LOG2_RD)-1:0]            data_out;

   byte                                  op_q[$];                  // Operation letters
   logic [31:0]                          addr_q[$];
   logic [31:0]                          data_q[$];
   logic [`RAM_LANES-1:0]                mask_q[$];
   logic [7:0]                           exp_q[$];                 // Expected read byte

   logic [7:0]                           last_out = '0;            // Output before the current read
   int                                   test_count  = 0;
   int                                   check_count = 0;
   int                                   error_count = 0;

   tb_clock_gen #(
      .PERIOD_NS    (40),
      .RESET_CYCLES (3)
   ) u_clock_gen (
      .clk_o        (clk),
      .rst_n_o      (rst_n)
   );

   // Both ports share one clock
   ram_var_top #(
      .LOG2WIDTH_WR (LOG2_WR),
      .LOG2WIDTH_RD (LOG2_RD),
      .REGISTERS    (1)
   ) uut (
      .rst_n_i      (rst_n),
      .wclk_i       (clk),
      .waddr_i      (waddr),
      .we_i         (we),
      .web_i        (web),
      .data_in_i    (data_in),
      .rclk_i       (clk),
      .raddr_i      (raddr),
      .ren_i        (ren),
      .regen_i      (regen),
      .data_out_o   (data_out)
   );

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      end
   endtask

   // Idle cycles with strobes low and regen untouched
   task automatic wait_edges(input int count);
      int seen;
      seen = 0;
      while (seen < count && seen < EDGE_LIMIT) begin
         @(posedge clk);
         we  <= 1'b0;
         ren <= 1'b0;
         seen++;
      end
      if (seen < count) begin
         error_count++;
         $display("Timeout: gave up after %0d of %0d clock edges", seen, count);
      end
   endtask

   task automatic wait_reset_release(output bit ok);
      int cycles;
      cycles = 0;
      while (rst_n !== 1'b1 && cycles < RESET_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      ok = (rst_n === 1'b1);
   endtask

   // Write lands on the following edge
   task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                             input logic [`RAM_LANES-1:0] mask);
      @(posedge clk);
      waddr   <= addr[WADDR_BITS-1:0];
      data_in <= data;
      web     <= mask;
      we      <= 1'b1;
      ren     <= 1'b0;
   endtask

   task automatic read_byte(input logic [31:0] addr, input bit hold, input logic [7:0] expv);
      @(posedge clk);
      raddr <= addr[RADDR_BITS-1:0];
      ren   <= 1'b1;
      we    <= 1'b0;
      regen <= !hold;
      if (hold) begin
         wait_edges(1);                                            // Array latches the row
         @(negedge clk);
         check_value("data_out_o", data_out, last_out);            // Output register holds
         wait_edges(1);
         regen <= 1'b1;                                            // Seen from the next edge on
         @(negedge clk);
         check_value("data_out_o", data_out, last_out);
         wait_edges(1);
      end else begin
         wait_edges(READ_LATENCY - 1);                             // Array latches the row
         @(negedge clk);
         check_value("data_out_o", data_out, last_out);            // New slice not loaded yet
         wait_edges(1);
      end
      @(negedge clk);
      check_value("data_out_o", data_out, expv);
      last_out = expv;
   endtask

   initial begin : watchdog
      #(RUN_LIMIT_NS);
      $display("Timeout: run went past %0d ns", RUN_LIMIT_NS);
      $display("Test failed");
      $finish;
   end

   initial begin : main_seq
      int          fd;
      int          rc;
      int          errs_before;
      string       line;
      byte         op;
      logic [31:0] f_addr;
      logic [31:0] f_data;
      logic [31:0] f_mask;
      logic [31:0] f_exp;
      bit          reset_ok;
      bit          prev_was_write;

      void'($urandom(SEED));
      waddr   = '0;
      we      = 1'b0;
      web     = '0;
      data_in = '0;
      raddr   = '0;
      ren     = 1'b0;
      regen   = 1'b1;
      prev_was_write = 1'b0;

      fd = $fopen("sim/ram_var_stimulus.txt", "r");
      if (fd == 0) begin
         error_count++;
         $display("Could not open the stimulus file");
      end else begin
         while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 0 && (line[0] == "W" || line[0] == "R" || line[0] == "H")) begin
               rc = $sscanf(line, "%c %h %h %h %h", op, f_addr, f_data, f_mask, f_exp);
               if (rc == 5) begin
                  op_q.push_back(op);
                  addr_q.push_back(f_addr);
                  data_q.push_back(f_data);
                  mask_q.push_back(f_mask[`RAM_LANES-1:0]);
                  exp_q.push_back(f_exp[7:0]);
               end
            end
         end
         $fclose(fd);
      end

      wait_reset_release(reset_ok);
      if (!reset_ok) begin
         error_count++;
         $display("Timeout: reset was never released");
      end else begin
         @(negedge clk);
         errs_before = error_count;
         check_value("data_out_o", data_out, 32'h0);               // Cleared by reset
         test_count++;
         $display("reset: output %h %s", data_out,
                  (error_count == errs_before) ? "ok" : "mismatch");

         for (int i = 0; i < op_q.size(); i++) begin
            // A read right after a write goes out on the next cycle
            if (!(prev_was_write && op_q[i] != "W")) begin
               wait_edges($urandom % 4);
            end
            errs_before = error_count;
            test_count++;
            if (op_q[i] == "W") begin
               write_word(addr_q[i], data_q[i], mask_q[i]);
               $display("op %0d: write %h <= %h web %h done", i, addr_q[i][WADDR_BITS-1:0],
                        data_q[i], mask_q[i]);
            end else begin
               read_byte(addr_q[i], op_q[i] == "H", exp_q[i]);
               $display("op %0d: %s %h -> %h %s", i, (op_q[i] == "H") ? "hold read" : "read",
                        addr_q[i][RADDR_BITS-1:0], exp_q[i],
                        (error_count == errs_before) ? "ok" : "mismatch");
            end
            prev_was_write = (op_q[i] == "W");
         end
         wait_edges(2);                                            // Drain the last write
      end

      if (op_q.size() == 0) begin
         error_count++;
         $display("No operations were read from the stimulus file");
      end
      $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
               error_count);
      if (error_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
